/* Bender.yml */
package:
  name: avg_chain

export_include_dirs:
  - .

sources:
  - avgPkg.sv
  - sampleCapture.sv
  - movingAverage.sv
  - outputStage.sv
  - avgChain.sv
  - target: simulation
    files:
      - avgChain_tb.sv

/* avgChain.f */
+incdir+.
avgPkg.sv
sampleCapture.sv
movingAverage.sv
outputStage.sv
avgChain.sv
avgChain_tb.sv

/* avgChain.sv */
`include "avgChain_consts.svh"
`default_nettype none

module avgChain
(
  input  logic             CLK,
  input  logic             CLR,
  input  logic             Sclk,
  input  avgPkg::sample_t  X,
  input  avgPkg::avgMode_e mode,
  input  logic             decim,
  input  logic             OE,
  output avgPkg::sample_t  Y,
  output logic             yValid
);

  avgPkg::sampleBeat_t capBeat;  // captured X, three cycles after Sclk rises.
  avgPkg::sampleBeat_t avgBeat;  // windowed mean, one cycle later.

  // ***********************************************************
  // Capture, average, output
  // ***********************************************************

  sampleCapture capture
  (
    .CLK     (CLK),
    .CLR     (CLR),
    .Sclk    (Sclk),
    .X       (X),
    .capBeat (capBeat)
  );

  movingAverage average
  (
    .CLK     (CLK),
    .CLR     (CLR),
    .mode    (mode),
    .capBeat (capBeat),
    .avgBeat (avgBeat)
  );

  outputStage outStage
  (
    .CLK     (CLK),
    .CLR     (CLR),
    .mode    (mode),
    .decim   (decim),
    .OE      (OE),
    .avgBeat (avgBeat),
    .Y       (Y),
    .yValid  (yValid)
  );

endmodule

`default_nettype wire

/* avgChain_consts.svh */
`ifndef AVGCHAIN_CONSTS_SVH
`define AVGCHAIN_CONSTS_SVH

// width of the ADC word on X and of the result on Y.
`define SAMPLE_WIDTH 16

// three guard bits, so a sum of eight samples cannot overflow.
`define SUM_WIDTH (`SAMPLE_WIDTH + 3)

// past samples kept; with the current one this gives the window of 8.
`define HIST_DEPTH 7

`endif

/* avgChain_tb.sv */
`include "avgChain_consts.svh"
`default_nettype none

module avgChain_tb;

  timeunit 1ns;
  timeprecision 100ps;

  logic             CLK;
  logic             CLR;
  logic             Sclk;
  avgPkg::sample_t  X;
  avgPkg::avgMode_e mode;
  logic             decim;
  logic             OE;
  avgPkg::sample_t  Y;
  logic             yValid;

  logic [15:0]      lfsrState = 16'd51;
  avgPkg::sample_t  modelHist [8];     // modelHist[0] is the newest past sample.
  avgPkg::avgMode_e curMode;
  logic             curDecim;
  int               modelPhase;
  int               sampleIndex;
  int               checkCount;
  int               errorCount;
  int               testErrStart;
  string            testName;

  avgChain UUT
  (
    .CLK    (CLK),
    .CLR    (CLR),
    .Sclk   (Sclk),
    .X      (X),
    .mode   (mode),
    .decim  (decim),
    .OE     (OE),
    .Y      (Y),
    .yValid (yValid)
  );

  initial
  begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // ***********************************************************
  // Random source and reference model
  // ***********************************************************

  function automatic logic lfsrStep();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit)
    begin
      lfsrState = lfsrState ^ 16'hB400;  // taps of a maximal 16-bit Galois LFSR.
    end
    return outBit;
  endfunction

  function automatic int randBits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      v = (v << 1) | lfsrStep();
    end
    return v;
  endfunction

  // a quarter of the samples each sit at the negative and positive extremes.
  function automatic avgPkg::sample_t randSample();
    int sel;
    sel = randBits(2);
    case (sel)
      0:       return {1'b1, {(`SAMPLE_WIDTH-1){1'b0}}};
      1:       return {1'b0, {(`SAMPLE_WIDTH-1){1'b1}}};
      default: return avgPkg::sample_t'(randBits(`SAMPLE_WIDTH));
    endcase
  endfunction

  function automatic int windowLen(input avgPkg::avgMode_e m);
    case (m)
      avgPkg::AVG2: return 2;
      avgPkg::AVG4: return 4;
      avgPkg::AVG8: return 8;
      default:      return 1;
    endcase
  endfunction

  task automatic modelStep(input avgPkg::sample_t x, output avgPkg::sample_t expY,
                           output logic kept);
    avgPkg::sum_t total;
    int           len;
    int           quot;
    len = windowLen(curMode);
    total = x;
    for (int i = 0; i < len - 1; i++)
    begin
      total = total + modelHist[i];
    end
    quot = total / len;
    if (((total % len) != 0) && (total < 0))
    begin
      quot = quot - 1;  // integer division truncates, the mean is floored.
    end
    expY = avgPkg::sample_t'(quot);
    kept = !curDecim || (modelPhase == 0);
    modelPhase = (modelPhase + 1) % len;
    for (int i = 7; i > 0; i--)
    begin
      modelHist[i] = modelHist[i-1];
    end
    modelHist[0] = x;
  endtask

  // ***********************************************************
  // Compare tasks
  // ***********************************************************

  task automatic checkSample(input string name, input avgPkg::sample_t actual,
                             input avgPkg::sample_t expected);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("** Error at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  task automatic checkBit(input string name, input logic actual, input logic expected);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("** Error at %0t: %s is %b, expected %b", $time, name, actual, expected);
    end
  endtask

  // ***********************************************************
  // Stimulus
  // ***********************************************************

  task automatic applyReset(input avgPkg::avgMode_e m, input logic d);
    @(posedge CLK);
    CLR   <= 1'b1;
    Sclk  <= 1'b0;
    mode  <= m;
    decim <= d;
    curMode = m;
    curDecim = d;
    modelPhase = 0;
    for (int i = 0; i < 8; i++)
    begin
      modelHist[i] = '0;
    end
    repeat (10)
    begin
      @(negedge CLK);
      checkSample("Y", Y, '0);
      checkBit("yValid", yValid, 1'b0);
      @(posedge CLK);
    end
    CLR <= 1'b0;
  endtask

  task automatic setOe(input logic v);
    @(posedge CLK);
    OE <= v;
    @(posedge CLK);  // let the output register see the new level.
  endtask

  // one Sclk period, then wait until the beat has left the chain.
  task automatic driveSample(input avgPkg::sample_t x, input int hiCycles, input int loCycles,
                             input logic expectPulse, input avgPkg::sample_t expY);
    int   edges;
    logic seen;
    edges = 0;
    seen = 1'b0;
    @(posedge CLK);
    X    <= x;
    Sclk <= 1'b1;
    while ((edges < hiCycles + loCycles) || (edges < 7) || (expectPulse && !seen))
    begin
      if (edges >= 20)
      begin
        errorCount++;
        $display("sample %0d: no output beat arrived within 20 cycles", sampleIndex);
        break;
      end
      @(posedge CLK);
      edges++;
      if (edges == hiCycles)
      begin
        Sclk <= 1'b0;
      end
      @(negedge CLK);
      checkBit("yValid", yValid, expectPulse && (edges == 5));
      if (yValid)
      begin
        seen = 1'b1;
        if (expectPulse)
        begin
          checkSample("Y", Y, expY);
        end
      end
      if (!OE)
      begin
        checkSample("Y", Y, '0);  // disabled output must read zero.
      end
    end
  endtask

  task automatic runSample();
    avgPkg::sample_t x;
    avgPkg::sample_t expY;
    logic            kept;
    int              hiCycles;
    int              loCycles;
    x = randSample();
    hiCycles = 2 + randBits(2);
    loCycles = 2 + randBits(2);
    modelStep(x, expY, kept);
    sampleIndex++;
    driveSample(x, hiCycles, loCycles, kept && OE, expY);
  endtask

  task automatic beginTest(input string name);
    testName = name;
    testErrStart = errorCount;
  endtask

  task automatic endTest();
    $display("test %s: %0d errors", testName, errorCount - testErrStart);
  endtask

  task automatic runTest(input string name, input avgPkg::avgMode_e m, input logic d,
                         input int count);
    beginTest(name);
    applyReset(m, d);
    setOe(1'b1);
    repeat (count) runSample();
    endTest();
  endtask

  // ***********************************************************
  // Test sequence
  // ***********************************************************

  initial
  begin
    CLR = 1'b1;
    Sclk = 1'b0;
    X = '0;
    mode = avgPkg::AVG1;
    decim = 1'b0;
    OE = 1'b0;
    sampleIndex = 0;
    checkCount = 0;
    errorCount = 0;

    runTest("pass-through AVG1", avgPkg::AVG1, 1'b0, 12);
    runTest("mean AVG2", avgPkg::AVG2, 1'b0, 20);
    runTest("mean AVG4", avgPkg::AVG4, 1'b0, 20);
    runTest("mean AVG8", avgPkg::AVG8, 1'b0, 24);
    runTest("decimation AVG2", avgPkg::AVG2, 1'b1, 12);
    runTest("decimation AVG4", avgPkg::AVG4, 1'b1, 16);
    runTest("decimation AVG8", avgPkg::AVG8, 1'b1, 24);

    beginTest("output enable");  // phase and history keep moving while OE is low.
    applyReset(avgPkg::AVG4, 1'b1);
    setOe(1'b1);
    repeat (6) runSample();
    setOe(1'b0);
    repeat (7) runSample();
    setOe(1'b1);
    repeat (10) runSample();
    endTest();

    beginTest("reset mid-stream");
    applyReset(avgPkg::AVG8, 1'b0);
    setOe(1'b1);
    repeat (5) runSample();
    applyReset(avgPkg::AVG8, 1'b0);
    repeat (9) runSample();
    endTest();

    $display("summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0)
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial
  begin
    #2000000;
    $display("simulation did not finish within 2 ms and was stopped");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* avgPkg.sv */
`include "avgChain_consts.svh"
`default_nettype none

package avgPkg;

  // ***********************************************************
  // Data words
  // ***********************************************************

  typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;
  typedef logic signed [`SUM_WIDTH-1:0]    sum_t;   // full-width window sum.

  // ***********************************************************
  // Window selection
  // ***********************************************************

  // the encoding is also the right shift that divides by the window.
  typedef enum logic [1:0]
  {
    AVG1 = 2'd0,
    AVG2 = 2'd1,
    AVG4 = 2'd2,
    AVG8 = 2'd3
  } avgMode_e;

  // ***********************************************************
  // Stage-to-stage beat
  // ***********************************************************

  typedef struct packed
  {
    logic    valid;  // one-cycle strobe.
    sample_t data;   // meaningful only while valid is high.
  } sampleBeat_t;

endpackage

`default_nettype wire

/* movingAverage.sv */
`include "avgChain_consts.svh"
`default_nettype none

module movingAverage
(
  input  logic                CLK,
  input  logic                CLR,
  input  avgPkg::avgMode_e    mode,
  input  avgPkg::sampleBeat_t capBeat,
  output avgPkg::sampleBeat_t avgBeat
);

  avgPkg::sample_t hist [`HIST_DEPTH];  // hist[0] holds the newest past sample.
  avgPkg::sum_t    windowSum;
  avgPkg::sum_t    windowMean;
  logic [1:0]      shiftAmt;
  logic [3:0]      tapCount;            // history entries that join the sum.

  // ***********************************************************
  // Window decode
  // ***********************************************************

  always_comb
  begin
    case (mode)
      avgPkg::AVG1:
      begin
        shiftAmt = 2'd0;
        tapCount = 4'd0;
      end
      avgPkg::AVG2:
      begin
        shiftAmt = 2'd1;
        tapCount = 4'd1;
      end
      avgPkg::AVG4:
      begin
        shiftAmt = 2'd2;
        tapCount = 4'd3;
      end
      avgPkg::AVG8:
      begin
        shiftAmt = 2'd3;
        tapCount = 4'd7;
      end
      default:
      begin
        shiftAmt = 2'd0;
        tapCount = 4'd0;
      end
    endcase
  end

  // ***********************************************************
  // Full-width sum and floored mean
  // ***********************************************************

  always_comb
  begin
    windowSum = capBeat.data;  // sign-extended to the sum width.
    for (int i = 0; i < `HIST_DEPTH; i++)
    begin
      if (i < tapCount)
      begin
        windowSum = windowSum + hist[i];
      end
    end
  end

  // arithmetic shift, so the mean rounds toward minus infinity.
  assign windowMean = windowSum >>> shiftAmt;

  // ***********************************************************
  // History and output register
  // ***********************************************************

  always_ff @(posedge CLK or posedge CLR)
  begin
    if (CLR)
    begin
      avgBeat <= '0;
      for (int i = 0; i < `HIST_DEPTH; i++)
      begin
        hist[i] <= '0;  // samples before reset count as zero.
      end
    end
    else
    begin
      avgBeat.valid <= capBeat.valid;
      if (capBeat.valid)
      begin
        avgBeat.data <= windowMean[`SAMPLE_WIDTH-1:0];  // the mean always fits.
        hist[0] <= capBeat.data;
        for (int i = 1; i < `HIST_DEPTH; i++)
        begin
          hist[i] <= hist[i-1];
        end
      end
    end
  end

  // the window is set up during reset and must be a legal code afterwards.
  modeKnown: assert property (
    @(posedge CLK) disable iff (CLR)
    !$isunknown(mode)
  );

endmodule

`default_nettype wire

/* outputStage.sv */
`include "avgChain_consts.svh"
`default_nettype none

module outputStage
(
  input  logic                CLK,
  input  logic                CLR,
  input  avgPkg::avgMode_e    mode,
  input  logic                decim,
  input  logic                OE,
  input  avgPkg::sampleBeat_t avgBeat,
  output avgPkg::sample_t     Y,
  output logic                yValid
);

  logic [2:0] phase;      // position of the next beat inside its window.
  logic [2:0] lastPhase;
  logic       keepBeat;

  always_comb
  begin
    case (mode)
      avgPkg::AVG1: lastPhase = 3'd0;
      avgPkg::AVG2: lastPhase = 3'd1;
      avgPkg::AVG4: lastPhase = 3'd3;
      avgPkg::AVG8: lastPhase = 3'd7;
      default:      lastPhase = 3'd0;
    endcase
  end

  // ***********************************************************
  // Decimation phase
  // ***********************************************************

  always_ff @(posedge CLK or posedge CLR)
  begin
    if (CLR)
    begin
      phase <= 3'd0;
    end
    else if (avgBeat.valid)
    begin
      phase <= (phase == lastPhase) ? 3'd0 : phase + 3'd1;  // runs even with OE low.
    end
  end

  assign keepBeat = avgBeat.valid & (~decim | (phase == 3'd0));

  // ***********************************************************
  // Output register
  // ***********************************************************

  always_ff @(posedge CLK or posedge CLR)
  begin
    if (CLR)
    begin
      Y      <= '0;
      yValid <= 1'b0;
    end
    else if (!OE)
    begin
      Y      <= '0;  // disabled output reads as zero.
      yValid <= 1'b0;
    end
    else
    begin
      yValid <= keepBeat;
      if (keepBeat)
      begin
        Y <= avgBeat.data;
      end
    end
  end

  // a strobe on Y is only ever seen while the output is enabled.
  validNeedsOe: assert property (
    @(posedge CLK) disable iff (CLR)
    yValid |-> OE
  );

endmodule

`default_nettype wire

/* sampleCapture.sv */
`include "avgChain_consts.svh"
`default_nettype none

module sampleCapture
(
  input  logic                CLK,
  input  logic                CLR,
  input  logic                Sclk,
  input  avgPkg::sample_t     X,
  output avgPkg::sampleBeat_t capBeat
);

  logic sclkMeta;  // first flop after the clock crossing.
  logic sclkSync;  // settled copy of Sclk in the CLK domain.
  logic sclkPrev;  // level of sclkSync one cycle earlier.
  logic sclkRise;

  // ***********************************************************
  // Sclk synchronizer and edge detect
  // ***********************************************************

  always_ff @(posedge CLK or posedge CLR)
  begin
    if (CLR)
    begin
      sclkMeta <= 1'b0;
      sclkSync <= 1'b0;
      sclkPrev <= 1'b0;
    end
    else
    begin
      sclkMeta <= Sclk;
      sclkSync <= sclkMeta;
      sclkPrev <= sclkSync;
    end
  end

  assign sclkRise = sclkSync & ~sclkPrev;  // high for one cycle per Sclk period.

  // ***********************************************************
  // Capture of X
  // ***********************************************************

  always_ff @(posedge CLK or posedge CLR)
  begin
    if (CLR)
    begin
      capBeat <= '0;
    end
    else
    begin
      capBeat.valid <= sclkRise;
      if (sclkRise)
      begin
        capBeat.data <= X;  // X has been stable since the Sclk edge.
      end
    end
  end

  // Sclk stays high and low for two cycles each, so strobes are at least three cycles apart.
  capPulseSingle: assert property (
    @(posedge CLK) disable iff (CLR)
    capBeat.valid |=> (!capBeat.valid) [*2]
  );

endmodule

`default_nettype wire
